// ==== common/gba_sound_settings.svh ====
`ifndef GBA_SOUND_SETTINGS_SVH
`define GBA_SOUND_SETTINGS_SVH

// mixed sample width, signed
`define SAMPLE_W 10

// clk_100 cycles per length tick, kept short for simulation
`define LEN_DIV 64

// length ticks per envelope tick
`define ENV_PER_LEN 4

// clk_100 cycles per frequency-timer step
`define TONE_DIV 4

// fifo word level that triggers a refill request
`define FIFO_REQ_LEVEL 4

`endif

// ==== common/gba_sound_pkg.sv ====
`include "gba_sound_settings.svh"

package gba_sound_pkg;

    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    typedef logic [3:0] level_t;

    // soundcnt_h[1:0], value 3 is not used by software
    typedef enum logic [1:0] {
        PSG_QUARTER = 2'd0,
        PSG_HALF    = 2'd1,
        PSG_FULL    = 2'd2
    } psg_vol_e;

    // soundcnt4 bit 3
    typedef enum logic {
        NOISE_W15 = 1'b0,
        NOISE_W7  = 1'b1
    } noise_width_e;

    typedef enum logic {
        DS_IDLE    = 1'b0,
        DS_PLAYING = 1'b1
    } ds_state_e;

endpackage

// ==== common/psg_bus_if.sv ====
`timescale 1ns/10ps

interface psg_bus_if;
    import gba_sound_pkg::*;

    level_t ch1;
    level_t ch2;
    level_t ch4;
    logic   on1;
    logic   on2;
    logic   on4;

    modport tone (
        output ch1, ch2, ch4,
        output on1, on2, on4
    );

    modport mixer (
        input ch1, ch2, ch4,
        input on1, on2, on4
    );

endinterface

// ==== verilog/frame_sequencer.sv ====
`timescale 1ns/10ps
`include "gba_sound_settings.svh"

module frame_sequencer (
    input  logic clk_100,
    input  logic arst_n,
    output logic len_tick,
    output logic env_tick
);
    localparam int CYC_W = $clog2(`LEN_DIV);
    localparam int ENV_W = $clog2(`ENV_PER_LEN);

    logic [CYC_W-1:0] cyc_cnt;
    logic [ENV_W-1:0] len_cnt;

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            cyc_cnt  <= '0;
            len_cnt  <= '0;
            len_tick <= 1'b0;
            env_tick <= 1'b0;
        end else begin
            len_tick <= 1'b0;
            env_tick <= 1'b0;
            if (cyc_cnt == CYC_W'(`LEN_DIV - 1)) begin
                cyc_cnt  <= '0;
                len_tick <= 1'b1;
                // envelope rides on every ENV_PER_LEN-th length tick
                if (len_cnt == ENV_W'(`ENV_PER_LEN - 1)) begin
                    len_cnt  <= '0;
                    env_tick <= 1'b1;
                end else begin
                    len_cnt <= len_cnt + 1'b1;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== psg/square_channel.sv ====
`timescale 1ns/10ps
`include "gba_sound_settings.svh"

module square_channel (
    input  logic                  clk_100,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic                  trig,
    input  logic                  len_tick,
    input  logic                  env_tick,
    input  logic [15:0]           duty_len,
    input  logic [15:0]           env_freq,
    output gba_sound_pkg::level_t level,
    output logic                  active
);
    import gba_sound_pkg::*;

    localparam int DIV_W = $clog2(`TONE_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [11:0]      freq_cnt;
    logic [11:0]      reload;
    logic [2:0]       step;
    logic [7:0]       pattern;
    logic [2:0]       env_cnt;
    logic [6:0]       len_cnt;
    level_t           volume;

    assign reload = 12'd2048 - 12'(env_freq[10:0]);

    always_comb begin
        case (duty_len[7:6])
            2'd0:    pattern = 8'b0000_0001;
            2'd1:    pattern = 8'b1000_0001;
            2'd2:    pattern = 8'b1000_0111;
            default: pattern = 8'b0111_1110;
        endcase
    end

    // frequency timer, one duty step per (2048 - freq) prescaled steps
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt  <= '0;
            freq_cnt <= '0;
            step     <= '0;
        end else if (!enable || trig) begin
            div_cnt  <= '0;
            freq_cnt <= reload;
            step     <= '0;
        end else if (div_cnt == DIV_W'(`TONE_DIV - 1)) begin
            div_cnt <= '0;
            if (freq_cnt <= 12'd1) begin
                freq_cnt <= reload;
                step     <= step + 3'd1;
            end else begin
                freq_cnt <= freq_cnt - 12'd1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // envelope and length counter
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            active  <= 1'b0;
            volume  <= '0;
            env_cnt <= '0;
            len_cnt <= '0;
        end else if (!enable) begin
            active  <= 1'b0;
            volume  <= '0;
            env_cnt <= '0;
            len_cnt <= '0;
        end else if (trig) begin
            active  <= 1'b1;
            volume  <= duty_len[15:12];
            env_cnt <= '0;
            len_cnt <= 7'd64 - 7'(duty_len[5:0]);
        end else begin
            if (env_tick && duty_len[10:8] != 3'd0) begin
                if (env_cnt == duty_len[10:8] - 3'd1) begin
                    env_cnt <= '0;
                    if (duty_len[11] && volume != 4'd15) begin
                        volume <= volume + 4'd1;
                    end else if (!duty_len[11] && volume != 4'd0) begin
                        volume <= volume - 4'd1;
                    end
                end else begin
                    env_cnt <= env_cnt + 3'd1;
                end
            end
            if (len_tick && env_freq[14] && active) begin
                if (len_cnt <= 7'd1) begin
                    len_cnt <= '0;
                    active  <= 1'b0;
                end else begin
                    len_cnt <= len_cnt - 7'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            level <= '0;
        end else begin
            level <= (active && pattern[step]) ? volume : '0;
        end
    end

endmodule

// ==== psg/noise_channel.sv ====
`timescale 1ns/10ps

module noise_channel (
    input  logic                  clk_100,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic                  trig,
    input  logic                  len_tick,
    input  logic                  env_tick,
    input  logic [15:0]           env_len,
    input  logic [15:0]           ctrl,
    output gba_sound_pkg::level_t level,
    output logic                  active
);
    import gba_sound_pkg::*;

    noise_width_e width;
    logic [3:0]   base;
    logic [18:0]  period;
    logic [18:0]  div_cnt;
    logic [14:0]  lfsr;
    logic [14:0]  lfsr_next;
    logic         fb;
    logic [2:0]   env_cnt;
    logic [6:0]   len_cnt;
    level_t       volume;

    assign width  = noise_width_e'(ctrl[3]);
    // ratio 0 counts as half of ratio 1
    assign base   = (ctrl[2:0] == 3'd0) ? 4'd1 : {ctrl[2:0], 1'b0};
    assign period = 19'(base) << ctrl[7:4];

    always_comb begin
        fb        = lfsr[0] ^ lfsr[1];
        lfsr_next = {fb, lfsr[14:1]};
        if (width == NOISE_W7) begin
            lfsr_next[6] = fb;
        end
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            lfsr    <= '1;
        end else if (!enable || trig) begin
            div_cnt <= period;
            lfsr    <= '1;
        end else if (div_cnt <= 19'd1) begin
            div_cnt <= period;
            lfsr    <= lfsr_next;
        end else begin
            div_cnt <= div_cnt - 19'd1;
        end
    end

    // envelope and length, same register layout as the square channels
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            active  <= 1'b0;
            volume  <= '0;
            env_cnt <= '0;
            len_cnt <= '0;
        end else if (!enable) begin
            active  <= 1'b0;
            volume  <= '0;
            env_cnt <= '0;
            len_cnt <= '0;
        end else if (trig) begin
            active  <= 1'b1;
            volume  <= env_len[15:12];
            env_cnt <= '0;
            len_cnt <= 7'd64 - 7'(env_len[5:0]);
        end else begin
            if (env_tick && env_len[10:8] != 3'd0) begin
                if (env_cnt == env_len[10:8] - 3'd1) begin
                    env_cnt <= '0;
                    if (env_len[11] && volume != 4'd15) begin
                        volume <= volume + 4'd1;
                    end else if (!env_len[11] && volume != 4'd0) begin
                        volume <= volume - 4'd1;
                    end
                end else begin
                    env_cnt <= env_cnt + 3'd1;
                end
            end
            if (len_tick && ctrl[14] && active) begin
                if (len_cnt <= 7'd1) begin
                    len_cnt <= '0;
                    active  <= 1'b0;
                end else begin
                    len_cnt <= len_cnt - 7'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            level <= '0;
        end else begin
            level <= (active && !lfsr[0]) ? volume : '0;
        end
    end

endmodule

// ==== psg/psg_mixer.sv ====
`timescale 1ns/10ps

module psg_mixer (
    input  logic                   clk_100,
    input  logic                   arst_n,
    psg_bus_if.mixer               bus,
    input  logic [15:0]            soundcnt_l,
    input  logic [15:0]            soundcnt_h,
    output gba_sound_pkg::sample_t psg_l,
    output gba_sound_pkg::sample_t psg_r
);
    import gba_sound_pkg::*;

    psg_vol_e   psg_vol;
    logic [5:0] sum_l;
    logic [5:0] sum_r;
    logic [8:0] scaled_l;
    logic [8:0] scaled_r;

    function automatic logic [8:0] apply_vol(logic [8:0] v, psg_vol_e sel);
        case (sel)
            PSG_QUARTER: return v >> 2;
            PSG_HALF:    return v >> 1;
            default:     return v;
        endcase
    endfunction

    assign psg_vol = psg_vol_e'(soundcnt_h[1:0]);

    // right enables at 8+n, left at 12+n
    always_comb begin
        sum_l = '0;
        sum_r = '0;
        if (bus.on1 && soundcnt_l[8])  sum_r = sum_r + 6'(bus.ch1);
        if (bus.on2 && soundcnt_l[9])  sum_r = sum_r + 6'(bus.ch2);
        if (bus.on4 && soundcnt_l[11]) sum_r = sum_r + 6'(bus.ch4);
        if (bus.on1 && soundcnt_l[12]) sum_l = sum_l + 6'(bus.ch1);
        if (bus.on2 && soundcnt_l[13]) sum_l = sum_l + 6'(bus.ch2);
        if (bus.on4 && soundcnt_l[15]) sum_l = sum_l + 6'(bus.ch4);
        scaled_r = 9'(sum_r) * (9'(soundcnt_l[2:0]) + 9'd1);
        scaled_l = 9'(sum_l) * (9'(soundcnt_l[6:4]) + 9'd1);
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            psg_l <= '0;
            psg_r <= '0;
        end else begin
            psg_l <= sample_t'({1'b0, apply_vol(scaled_l, psg_vol)});
            psg_r <= sample_t'({1'b0, apply_vol(scaled_r, psg_vol)});
        end
    end

endmodule

// ==== verilog/direct_sound.sv ====
`timescale 1ns/10ps
`include "gba_sound_settings.svh"

module direct_sound (
    input  logic                   clk_100,
    input  logic                   arst_n,
    input  logic                   timer_ovf,
    input  logic                   ds_reset,
    input  logic                   full_vol,
    input  logic [3:0]             fifo_level,
    input  logic [31:0]            fifo_data,
    output logic                   fifo_rd,
    output logic                   fifo_clr,
    output logic                   sound_req,
    output gba_sound_pkg::sample_t ds_sample
);
    import gba_sound_pkg::*;

    ds_state_e  state;
    logic [1:0] byte_idx;
    logic [1:0] sel;
    logic [7:0] cur_byte;
    sample_t    scaled;
    logic       advance;

    assign advance = timer_ovf && (fifo_level != 4'd0);
    // a fresh start always begins at the low byte of the head word
    assign sel      = (state == DS_IDLE) ? 2'd0 : byte_idx;
    assign cur_byte = fifo_data[{sel, 3'b000} +: 8];
    assign scaled   = full_vol ? sample_t'({cur_byte, 2'b00})
                               : sample_t'({cur_byte[7], cur_byte, 1'b0});

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            state     <= DS_IDLE;
            byte_idx  <= '0;
            ds_sample <= '0;
            fifo_rd   <= 1'b0;
            fifo_clr  <= 1'b0;
            sound_req <= 1'b0;
        end else begin
            fifo_rd   <= 1'b0;
            sound_req <= 1'b0;
            fifo_clr  <= ds_reset;
            if (ds_reset) begin
                state     <= DS_IDLE;
                byte_idx  <= '0;
                ds_sample <= '0;
            end else if (advance) begin
                state     <= DS_PLAYING;
                byte_idx  <= sel + 2'd1;
                ds_sample <= scaled;
                // last byte of the word pops the fifo
                if (sel == 2'd3) begin
                    fifo_rd   <= 1'b1;
                    sound_req <= (fifo_level - 4'd1) <= 4'(`FIFO_REQ_LEVEL);
                end
            end
        end
    end

endmodule

// ==== verilog/sound_mixer.sv ====
`timescale 1ns/10ps
`include "gba_sound_settings.svh"

module sound_mixer (
    input  logic                   clk_100,
    input  logic                   arst_n,
    input  logic                   sample_tick,
    input  gba_sound_pkg::sample_t psg_l,
    input  gba_sound_pkg::sample_t psg_r,
    input  gba_sound_pkg::sample_t ds_a,
    input  gba_sound_pkg::sample_t ds_b,
    input  logic [15:0]            soundcnt_h,
    output gba_sound_pkg::sample_t out_l,
    output gba_sound_pkg::sample_t out_r,
    output logic                   out_valid
);
    import gba_sound_pkg::*;

    localparam int SUM_W = `SAMPLE_W + 2;

    logic signed [SUM_W-1:0] sum_l;
    logic signed [SUM_W-1:0] sum_r;
    sample_t                 mix_l;
    sample_t                 mix_r;

    function automatic sample_t clamp(logic signed [SUM_W-1:0] v);
        if (v > SUM_W'(511)) return sample_t'(511);
        if (v < -SUM_W'(512)) return sample_t'(-512);
        return sample_t'(v[`SAMPLE_W-1:0]);
    endfunction

    always_comb begin
        sum_l = SUM_W'(psg_l);
        sum_r = SUM_W'(psg_r);
        if (soundcnt_h[8])  sum_r = sum_r + SUM_W'(ds_a);
        if (soundcnt_h[9])  sum_l = sum_l + SUM_W'(ds_a);
        if (soundcnt_h[12]) sum_r = sum_r + SUM_W'(ds_b);
        if (soundcnt_h[13]) sum_l = sum_l + SUM_W'(ds_b);
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            mix_l     <= '0;
            mix_r     <= '0;
            out_l     <= '0;
            out_r     <= '0;
            out_valid <= 1'b0;
        end else begin
            mix_l     <= clamp(sum_l);
            mix_r     <= clamp(sum_r);
            out_valid <= sample_tick;
            // codec side takes the pair on its strobe
            if (sample_tick) begin
                out_l <= mix_l;
                out_r <= mix_r;
            end
        end
    end

endmodule

// ==== verilog/gba_sound_top.sv ====
`timescale 1ns/10ps

module gba_sound_top (
    input  logic                   clk_100,
    input  logic                   arst_n,
    input  logic                   sample_tick,
    input  logic                   trig1,
    input  logic                   trig2,
    input  logic                   trig4,
    input  logic                   timer0_ovf,
    input  logic                   timer1_ovf,
    input  logic                   ds_a_reset,
    input  logic                   ds_b_reset,
    input  logic [15:0]            sound1cnt_h,
    input  logic [15:0]            sound1cnt_x,
    input  logic [15:0]            sound2cnt_l,
    input  logic [15:0]            sound2cnt_h,
    input  logic [15:0]            sound4cnt_l,
    input  logic [15:0]            sound4cnt_h,
    input  logic [15:0]            soundcnt_l,
    input  logic [15:0]            soundcnt_h,
    input  logic [15:0]            soundcnt_x,
    input  logic [3:0]             fifo_level_a,
    input  logic [3:0]             fifo_level_b,
    input  logic [31:0]            fifo_data_a,
    input  logic [31:0]            fifo_data_b,
    output logic                   fifo_rd_a,
    output logic                   fifo_rd_b,
    output logic                   fifo_clr_a,
    output logic                   fifo_clr_b,
    output logic                   sound_req_a,
    output logic                   sound_req_b,
    output gba_sound_pkg::sample_t out_l,
    output gba_sound_pkg::sample_t out_r,
    output logic                   out_valid
);
    import gba_sound_pkg::*;

    logic    len_tick;
    logic    env_tick;
    logic    timer_a;
    logic    timer_b;
    sample_t psg_l;
    sample_t psg_r;
    sample_t ds_a_sample;
    sample_t ds_b_sample;

    psg_bus_if psg_bus ();

    // timer select bits for each direct channel
    assign timer_a = soundcnt_h[10] ? timer1_ovf : timer0_ovf;
    assign timer_b = soundcnt_h[14] ? timer1_ovf : timer0_ovf;

    frame_sequencer u_frame_sequencer (
        .clk_100, .arst_n, .len_tick, .env_tick
    );

    square_channel sq1 (
        .clk_100, .arst_n, .enable(soundcnt_x[7]), .trig(trig1),
        .len_tick, .env_tick, .duty_len(sound1cnt_h), .env_freq(sound1cnt_x),
        .level(psg_bus.ch1), .active(psg_bus.on1)
    );

    square_channel sq2 (
        .clk_100, .arst_n, .enable(soundcnt_x[7]), .trig(trig2),
        .len_tick, .env_tick, .duty_len(sound2cnt_l), .env_freq(sound2cnt_h),
        .level(psg_bus.ch2), .active(psg_bus.on2)
    );

    noise_channel u_noise_channel (
        .clk_100, .arst_n, .enable(soundcnt_x[7]), .trig(trig4),
        .len_tick, .env_tick, .env_len(sound4cnt_l), .ctrl(sound4cnt_h),
        .level(psg_bus.ch4), .active(psg_bus.on4)
    );

    psg_mixer u_psg_mixer (
        .clk_100, .arst_n, .bus(psg_bus.mixer),
        .soundcnt_l, .soundcnt_h, .psg_l, .psg_r
    );

    direct_sound ds_a (
        .clk_100, .arst_n, .timer_ovf(timer_a), .ds_reset(ds_a_reset),
        .full_vol(soundcnt_h[2]), .fifo_level(fifo_level_a), .fifo_data(fifo_data_a),
        .fifo_rd(fifo_rd_a), .fifo_clr(fifo_clr_a), .sound_req(sound_req_a),
        .ds_sample(ds_a_sample)
    );

    direct_sound ds_b (
        .clk_100, .arst_n, .timer_ovf(timer_b), .ds_reset(ds_b_reset),
        .full_vol(soundcnt_h[3]), .fifo_level(fifo_level_b), .fifo_data(fifo_data_b),
        .fifo_rd(fifo_rd_b), .fifo_clr(fifo_clr_b), .sound_req(sound_req_b),
        .ds_sample(ds_b_sample)
    );

    sound_mixer u_sound_mixer (
        .clk_100, .arst_n, .sample_tick, .psg_l, .psg_r,
        .ds_a(ds_a_sample), .ds_b(ds_b_sample), .soundcnt_h,
        .out_l, .out_r, .out_valid
    );

endmodule

// ==== tests/tb_gba_sound.sv ====
`timescale 1ns/10ps
`include "gba_sound_settings.svh"

module tb_gba_sound;
    import gba_sound_pkg::*;

    localparam int TIMEOUT = 200;

    logic        clk_100;
    logic        arst_n;
    logic        sample_tick;
    logic        trig1;
    logic        trig2;
    logic        trig4;
    logic        timer0_ovf;
    logic        timer1_ovf;
    logic        ds_a_reset;
    logic        ds_b_reset;
    logic [15:0] sound1cnt_h;
    logic [15:0] sound1cnt_x;
    logic [15:0] sound2cnt_l;
    logic [15:0] sound2cnt_h;
    logic [15:0] sound4cnt_l;
    logic [15:0] sound4cnt_h;
    logic [15:0] soundcnt_l;
    logic [15:0] soundcnt_h;
    logic [15:0] soundcnt_x;
    logic [3:0]  fifo_level_a;
    logic [3:0]  fifo_level_b;
    logic [31:0] fifo_data_a;
    logic [31:0] fifo_data_b;
    logic        fifo_rd_a;
    logic        fifo_rd_b;
    logic        fifo_clr_a;
    logic        fifo_clr_b;
    logic        sound_req_a;
    logic        sound_req_b;
    sample_t     out_l;
    sample_t     out_r;
    logic        out_valid;

    // behavioral fall-through fifos and the bytes the DUT should play
    logic [31:0] fifo_a_q[$];
    logic [31:0] fifo_b_q[$];
    logic [7:0]  exp_bytes[$];
    logic [31:0] lcg_state;
    int          errors;
    int          checks;

    gba_sound_top u_gba_sound_top (.*);

    always #10 clk_100 = ~clk_100;

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic int clamp_sample(int v);
        if (v > 511) begin
            return 511;
        end
        if (v < -512) begin
            return -512;
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive_fifo_ports();
        fifo_level_a = (fifo_a_q.size() > 15) ? 4'd15 : 4'(fifo_a_q.size());
        fifo_level_b = (fifo_b_q.size() > 15) ? 4'd15 : 4'(fifo_b_q.size());
        fifo_data_a  = (fifo_a_q.size() > 0) ? fifo_a_q[0] : 32'd0;
        fifo_data_b  = (fifo_b_q.size() > 0) ? fifo_b_q[0] : 32'd0;
    endtask

    // pops and clears follow the DUT strobes seen on this edge
    task automatic service_fifos();
        if (fifo_clr_a) begin
            fifo_a_q.delete();
        end else if (fifo_rd_a && fifo_a_q.size() > 0) begin
            void'(fifo_a_q.pop_front());
        end
        if (fifo_clr_b) begin
            fifo_b_q.delete();
        end else if (fifo_rd_b && fifo_b_q.size() > 0) begin
            void'(fifo_b_q.pop_front());
        end
        drive_fifo_ports();
    endtask

    task automatic tick();
        @(negedge clk_100);
        service_fifos();
    endtask

    task automatic ticks(input int n);
        repeat (n) tick();
    endtask

    task automatic push_word(input bit chan_b, input logic [31:0] word);
        if (chan_b) begin
            fifo_b_q.push_back(word);
        end else begin
            fifo_a_q.push_back(word);
        end
        for (int i = 0; i < 4; i++) begin
            exp_bytes.push_back(word[8*i +: 8]);
        end
        drive_fifo_ports();
    endtask

    task automatic fill_fifo(input bit chan_b, input int words);
        logic [31:0] word;
        for (int w = 0; w < words; w++) begin
            word = {lcg_byte(), lcg_byte(), lcg_byte(), lcg_byte()};
            push_word(chan_b, word);
        end
    endtask

    task automatic pulse_ds_reset(input bit chan_b);
        ds_a_reset = !chan_b;
        ds_b_reset = chan_b;
        tick();
        ds_a_reset = 1'b0;
        ds_b_reset = 1'b0;
        if (chan_b) begin
            check("fifo_clr_b", fifo_clr_b, 1);
        end else begin
            check("fifo_clr_a", fifo_clr_a, 1);
        end
        exp_bytes.delete();
        tick();
    endtask

    task automatic take_sample();
        int n;
        sample_tick = 1'b1;
        tick();
        sample_tick = 1'b0;
        n = 0;
        while (!out_valid && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!out_valid) begin
            errors++;
            $display("out_valid never came after sample_tick at %0t", $time);
        end
    endtask

    task automatic wait_left_nonzero(input string what);
        int n;
        n = 0;
        take_sample();
        while (out_l == 0 && n < TIMEOUT) begin
            take_sample();
            n++;
        end
        if (out_l == 0) begin
            errors++;
            $display("%s never showed up on out_l", what);
        end
    endtask

    task automatic outputs_after_reset();
        check("out_valid", out_valid, 0);
        check("fifo_rd_a", fifo_rd_a, 0);
        check("fifo_rd_b", fifo_rd_b, 0);
        check("fifo_clr_a", fifo_clr_a, 0);
        check("fifo_clr_b", fifo_clr_b, 0);
        check("sound_req_a", sound_req_a, 0);
        check("sound_req_b", sound_req_b, 0);
        take_sample();
        check("out_l", out_l, 0);
        check("out_r", out_r, 0);
    endtask

    task automatic direct_a_full_left();
        logic [7:0] b;
        int         words;
        bit         last;
        soundcnt_x = 16'h0000;
        soundcnt_l = 16'h0000;
        // A left, full volume, timer0
        soundcnt_h = 16'h0204;
        pulse_ds_reset(0);
        fill_fifo(0, 8);
        words = 8;
        for (int k = 0; k < 20; k++) begin
            b = exp_bytes.pop_front();
            last = (k % 4 == 3);
            timer0_ovf = 1'b1;
            tick();
            timer0_ovf = 1'b0;
            check("fifo_rd_a", fifo_rd_a, last);
            check("sound_req_a", sound_req_a, last && (words - 1 <= `FIFO_REQ_LEVEL));
            if (last) begin
                words--;
            end
            ticks(3);
            take_sample();
            check("out_l", out_l, clamp_sample(int'($signed(b)) * 4));
            check("out_r", out_r, 0);
        end
    endtask

    task automatic direct_b_half_right();
        logic [7:0] b;
        // B right, half volume, timer1
        soundcnt_h = 16'h5000;
        pulse_ds_reset(1);
        fill_fifo(1, 4);
        for (int k = 0; k < 8; k++) begin
            b = exp_bytes.pop_front();
            timer1_ovf = 1'b1;
            tick();
            timer1_ovf = 1'b0;
            ticks(3);
            take_sample();
            check("out_r", out_r, int'($signed(b)) * 2);
            check("out_l", out_l, 0);
        end
        pulse_ds_reset(1);
        ticks(2);
        take_sample();
        check("out_r", out_r, 0);
    endtask

    task automatic tone_and_noise_levels();
        bit         lo_l;
        bit         hi_l;
        bit         lo_r;
        bit         hi_r;
        logic [7:0] gap;
        lo_l = 0;
        hi_l = 0;
        lo_r = 0;
        hi_r = 0;
        soundcnt_h  = 16'h0002;
        // ch1 left, noise right, left master 7, right master 0
        soundcnt_l  = 16'h1870;
        soundcnt_x  = 16'h0080;
        sound1cnt_h = 16'hF0C0;
        sound1cnt_x = 16'h07F8;
        sound4cnt_l = 16'h8000;
        sound4cnt_h = 16'h0000;
        tick();
        trig1 = 1'b1;
        trig4 = 1'b1;
        tick();
        trig1 = 1'b0;
        trig4 = 1'b0;
        ticks(4);
        for (int k = 0; k < 200; k++) begin
            gap = lcg_byte() % 8;
            ticks(1 + int'(gap));
            take_sample();
            // a nonzero level can only be the full tone
            if (out_l != 0) begin
                check("out_l", out_l, 120);
            end
            if (out_r != 0) begin
                check("out_r", out_r, 8);
            end
            lo_l |= (out_l == 0);
            hi_l |= (out_l == 120);
            lo_r |= (out_r == 0);
            hi_r |= (out_r == 8);
        end
        check("out_l at 0", lo_l, 1);
        check("out_l at 120", hi_l, 1);
        check("out_r at 0", lo_r, 1);
        check("out_r at 8", hi_r, 1);
    endtask

    task automatic length_and_decay();
        // ch2 alone, 4 length ticks to live
        soundcnt_l  = 16'h2070;
        sound2cnt_l = 16'hF0BC;
        sound2cnt_h = 16'h47F8;
        trig2 = 1'b1;
        tick();
        trig2 = 1'b0;
        wait_left_nonzero("channel 2");
        check("out_l", out_l, 120);
        ticks(8 * `LEN_DIV);
        for (int k = 0; k < 20; k++) begin
            ticks(5);
            take_sample();
            check("out_l", out_l, 0);
        end
        // ch1 decaying one step per envelope tick
        soundcnt_l  = 16'h1070;
        sound1cnt_h = 16'hF1C0;
        sound1cnt_x = 16'h07F8;
        trig1 = 1'b1;
        tick();
        trig1 = 1'b0;
        wait_left_nonzero("channel 1");
        ticks(17 * `ENV_PER_LEN * `LEN_DIV);
        for (int k = 0; k < 40; k++) begin
            ticks(7);
            take_sample();
            check("out_l", out_l, 0);
        end
    endtask

    task automatic saturated_left();
        soundcnt_l  = 16'h3070;
        soundcnt_h  = 16'h0206;
        // duty step 0 is high and lasts 8192 cycles at frequency 0
        sound1cnt_h = 16'hF000;
        sound1cnt_x = 16'h0000;
        sound2cnt_l = 16'hF000;
        sound2cnt_h = 16'h0000;
        trig1 = 1'b1;
        trig2 = 1'b1;
        tick();
        trig1 = 1'b0;
        trig2 = 1'b0;
        pulse_ds_reset(0);
        push_word(0, 32'h7F7F_7F7F);
        timer0_ovf = 1'b1;
        tick();
        timer0_ovf = 1'b0;
        ticks(3);
        take_sample();
        check("out_l", out_l, 511);
        check("out_r", out_r, 0);
    endtask

    initial begin
        clk_100     = 1'b0;
        arst_n      = 1'b0;
        sample_tick = 1'b0;
        trig1       = 1'b0;
        trig2       = 1'b0;
        trig4       = 1'b0;
        timer0_ovf  = 1'b0;
        timer1_ovf  = 1'b0;
        ds_a_reset  = 1'b0;
        ds_b_reset  = 1'b0;
        sound1cnt_h = '0;
        sound1cnt_x = '0;
        sound2cnt_l = '0;
        sound2cnt_h = '0;
        sound4cnt_l = '0;
        sound4cnt_h = '0;
        soundcnt_l  = '0;
        soundcnt_h  = '0;
        soundcnt_x  = '0;
        lcg_state   = 32'd50713;
        errors      = 0;
        checks      = 0;
        drive_fifo_ports();
        repeat (8) @(posedge clk_100);
        @(negedge clk_100);
        arst_n = 1'b1;
        tick();
        outputs_after_reset();
        direct_a_full_left();
        direct_b_half_right();
        tone_and_noise_levels();
        length_and_decay();
        saturated_left();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== gba_sound.f ====
+incdir+common
common/gba_sound_pkg.sv
common/psg_bus_if.sv
verilog/frame_sequencer.sv
psg/square_channel.sv
psg/noise_channel.sv
psg/psg_mixer.sv
verilog/direct_sound.sv
verilog/sound_mixer.sv
verilog/gba_sound_top.sv
tests/tb_gba_sound.sv

// ==== run_sim.sh ====
#!/bin/sh
# build tb_gba_sound with Verilator, run it, and look for the pass line in the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal -f gba_sound.f --top-module tb_gba_sound \
    -Mdir obj_dir > build.log 2>&1 &&
./obj_dir/Vtb_gba_sound > sim.log 2>&1 ||
{ cat build.log; echo "build or run error"; exit 1; }
grep -qx "sim passed" sim.log && echo "PASS" || { cat sim.log; exit 1; }
